// File: tb.f
verilog/soc_pkg.sv
verilog/soc_bus_decode.sv
verilog/soc_bus_response.sv
verilog/soc_ram.sv
verilog/soc_timer.sv
verilog/soc_top.sv
bench/soc_checker.sv
bench/tb_soc.sv

// File: Bender.yml
package:
  name: soc_bus

sources:
  - verilog/soc_pkg.sv
  - verilog/soc_bus_decode.sv
  - verilog/soc_bus_response.sv
  - verilog/soc_ram.sv
  - verilog/soc_timer.sv
  - verilog/soc_top.sv
  - target: simulation
    files:
      - bench/soc_checker.sv
      - bench/tb_soc.sv

// File: bench/tb_soc.sv
`timescale 1ns/1ps

module tb_soc;

	localparam int STEP_MAX = 20;
	localparam int ACCESS_TIMEOUT = 200;
	localparam int IRQ_TIMEOUT = 100;

	// Table row where rand_data swaps wdata for a random word
	typedef struct packed {
		logic [127:0] name;
		logic rw;
		logic [soc_pkg::ADDR_W-1:0] address;
		logic [soc_pkg::DATA_W-1:0] wdata;
		logic rand_data;
		logic expect_fault;
	} step_t;

	logic clock;
	logic reset;
	soc_pkg::bus_req_t bus_req;
	soc_pkg::bus_rsp_t bus_rsp;
	logic fault;
	logic [soc_pkg::ADDR_W-1:0] fault_address;
	logic timer_interrupt;

	logic [127:0] step_name;
	logic step_fault;
	step_t steps [STEP_MAX];
	int step_count;
	int tests;
	int failed;
	int bench_tests;
	int bench_failed;
	logic timed_out;
	int unsigned seed_draw;

	soc_top uut(
		.i_clock(clock),
		.i_reset(reset),
		.i_bus(bus_req),
		.o_bus(bus_rsp),
		.o_fault(fault),
		.o_fault_address(fault_address),
		.o_timer_interrupt(timer_interrupt)
	);

	soc_checker scoreboard(
		.i_clock(clock),
		.i_reset(reset),
		.i_bus(bus_req),
		.i_rsp(bus_rsp),
		.i_fault(fault),
		.i_fault_address(fault_address),
		.i_timer_interrupt(timer_interrupt),
		.i_name(step_name),
		.i_expect_fault(step_fault),
		.i_ram_words(uut.RAM_WORDS),
		.i_sdram_words(uut.SDRAM_WORDS),
		.i_sdram_latency(uut.SDRAM_LATENCY),
		.o_tests(tests),
		.o_failed(failed)
	);

	always #4 clock = ~clock;

	task automatic add_step(input logic [127:0] name, input logic rw,
		input logic [31:0] address, input logic [31:0] wdata,
		input logic rand_data, input logic expect_fault);
		steps[step_count] = {name, rw, address, wdata, rand_data, expect_fault};
		step_count++;
	endtask

	// ========================================
	// Stimulus table
	// ========================================

	task automatic build_table();
		logic [31:0] ram_span;
		logic [31:0] sdram_span;
		ram_span = uut.RAM_WORDS << soc_pkg::WORD_LSH;
		sdram_span = uut.SDRAM_WORDS << soc_pkg::WORD_LSH;
		step_count = 0;
		add_step("ram_wr", 1, 32'h1000_0010, 32'h0, 1, 0);
		add_step("ram_rd", 0, 32'h1000_0010, 32'h0, 0, 0);
		add_step("sdram_wr", 1, 32'h2000_0100, 32'h0, 1, 0);
		add_step("sdram_rd", 0, 32'h2000_0100, 32'h0, 0, 0);
		// Same word seen one region size higher
		add_step("ram_wrap_wr", 1, 32'h1000_0020, 32'h0, 1, 0);
		add_step("ram_wrap_rd", 0, 32'h1000_0020 + ram_span, 32'h0, 0, 0);
		add_step("sdram_wrap_wr", 1, 32'h2000_0040 + sdram_span, 32'h0, 1, 0);
		add_step("sdram_wrap_rd", 0, 32'h2000_0040, 32'h0, 0, 0);
		add_step("ram_rd_again", 0, 32'h1000_0010, 32'h0, 0, 0);
		// Region 5 is not mapped
		add_step("fault_first", 0, 32'h5000_0044, 32'h0, 0, 1);
		add_step("fault_second", 1, 32'h5000_0100, 32'h1234_5678, 0, 1);
		add_step("tmr_cmp_wr", 1, 32'ha000_0004, 32'hffff_f000, 0, 1);
		add_step("tmr_cmp_rd", 0, 32'ha000_0004, 32'h0, 0, 1);
		add_step("tmr_cnt_rd0", 0, 32'ha000_0000, 32'h0, 0, 1);
		add_step("tmr_cnt_rd1", 0, 32'ha000_0000, 32'h0, 0, 1);
		add_step("tmr_cmp_small", 1, 32'ha000_0004, 32'h0000_0040, 0, 1);
		add_step("tmr_cmp_rd2", 0, 32'ha000_0004, 32'h0, 0, 1);
	endtask

	// One access under the request and ready rule
	task automatic run_step(input step_t s);
		int waited;
		@(posedge clock);
		step_name <= s.name;
		step_fault <= s.expect_fault;
		bus_req.request <= 1'b1;
		bus_req.rw <= s.rw;
		bus_req.address <= s.address;
		bus_req.wdata <= s.rand_data ? $urandom() : s.wdata;
		waited = 0;
		do begin
			@(negedge clock);
			waited++;
		end while (!bus_rsp.ready && waited < ACCESS_TIMEOUT);
		if (!bus_rsp.ready) begin
			$display("ERROR: access %0s got no ready after %0d cycles", s.name, waited);
			timed_out = 1'b1;
			bench_failed++;
		end else begin
			@(posedge clock);
			bus_req.request <= 1'b0;
		end
	endtask

	task automatic wait_interrupt();
		int waited;
		waited = 0;
		bench_tests++;
		do begin
			@(negedge clock);
			waited++;
		end while (!timer_interrupt && waited < IRQ_TIMEOUT);
		if (timer_interrupt) begin
			$display("ok   timer_irq  rose after %0d cycles", waited);
		end else begin
			$display("ERROR: timer interrupt did not rise within %0d cycles", IRQ_TIMEOUT);
			bench_failed++;
		end
	endtask

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		seed_draw = $urandom(32'hbea0);
		reset = 1'b1;
		bus_req = '0;
		step_name = '0;
		step_fault = 1'b0;
		clock = 1'b0;
		timed_out = 1'b0;
		bench_tests = 0;
		bench_failed = 0;
		build_table();
		repeat (3) @(posedge clock);
		reset <= 1'b0;
		for (int i = 0; i < step_count && !timed_out; i++)
			run_step(steps[i]);
		if (!timed_out)
			wait_interrupt();
		$display("%0d tests, %0d failed", tests + bench_tests, failed + bench_failed);
		if (failed == 0 && bench_failed == 0)
			$display("** PASS **");
		else
			$display("** FAIL **");
		$finish;
	end

endmodule

// File: bench/soc_checker.sv
`timescale 1ns/1ps

module soc_checker(
	input logic i_clock,
	input logic i_reset,

	input soc_pkg::bus_req_t i_bus,
	input soc_pkg::bus_rsp_t i_rsp,
	input logic i_fault,
	input logic [soc_pkg::ADDR_W-1:0] i_fault_address,
	input logic i_timer_interrupt,

	// Current table row, driven by the testbench top
	input logic [127:0] i_name,
	input logic i_expect_fault,

	input int i_ram_words,
	input int i_sdram_words,
	input int i_sdram_latency,

	output int o_tests,
	output int o_failed
);

	// Shadow copies of both memory regions
	logic [soc_pkg::DATA_W-1:0] ram_shadow [];
	logic [soc_pkg::DATA_W-1:0] sdram_shadow [];

	logic [soc_pkg::DATA_W-1:0] compare_shadow;
	logic [soc_pkg::DATA_W-1:0] last_count;
	logic [soc_pkg::ADDR_W-1:0] first_fault;
	logic fault_seen;
	logic irq_error;
	int cycles;
	int bad;

	task automatic expect_value(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("MISMATCH %0s %0s expected %h actual %h", i_name, what, exp, act);
			bad++;
		end
	endtask

	// ========================================
	// One completed access
	// ========================================

	task automatic check_access();
		logic [3:0] region;
		logic [2:0] reg_offset;
		int index;
		int exp_cycles;
		bad = 0;
		region = i_bus.address[31:28];
		reg_offset = i_bus.address[4:2];
		index = int'(i_bus.address[27:2]);
		exp_cycles = 1;
		case (region)
			soc_pkg::REGION_RAM: begin
				index = index % i_ram_words;
				if (i_bus.rw)
					ram_shadow[index] = i_bus.wdata;
				else
					expect_value("rdata", ram_shadow[index], i_rsp.rdata);
			end
			soc_pkg::REGION_SDRAM: begin
				index = index % i_sdram_words;
				exp_cycles = i_sdram_latency;
				if (i_bus.rw)
					sdram_shadow[index] = i_bus.wdata;
				else
					expect_value("rdata", sdram_shadow[index], i_rsp.rdata);
			end
			soc_pkg::REGION_TIMER: begin
				if (reg_offset == soc_pkg::TIMER_REG_COMPARE) begin
					if (i_bus.rw)
						compare_shadow = i_bus.wdata;
					else
						expect_value("compare", compare_shadow, i_rsp.rdata);
				end else if (reg_offset == soc_pkg::TIMER_REG_COUNT && !i_bus.rw) begin
					if (i_rsp.rdata < last_count) begin
						$display("ERROR: %0s timer count went backwards from %h to %h",
							i_name, last_count, i_rsp.rdata);
						bad++;
					end
					last_count = i_rsp.rdata;
				end
			end
			default: begin
				// Unmapped, only the first address is kept
				if (!fault_seen)
					first_fault = i_bus.address;
				fault_seen = 1'b1;
				expect_value("rdata", '0, i_rsp.rdata);
				expect_value("fault_address", first_fault, i_fault_address);
			end
		endcase
		expect_value("fault", i_expect_fault, i_fault);
		expect_value("latency", exp_cycles, cycles);
		o_tests++;
		if (bad != 0)
			o_failed++;
		else
			$display("ok   %0s  %0d cycles", i_name, cycles);
	endtask

	// Sample mid cycle where every output is settled
	always @(negedge i_clock) begin
		if (i_reset) begin
			ram_shadow = new[i_ram_words];
			sdram_shadow = new[i_sdram_words];
			compare_shadow = '1;
			last_count = '0;
			first_fault = '0;
			fault_seen = 1'b0;
			irq_error = 1'b0;
			cycles = 0;
			o_tests = 0;
			o_failed = 0;
		end else begin
			// Compare still at its reset value
			if (compare_shadow == '1 && i_timer_interrupt && !irq_error) begin
				$display("ERROR: timer interrupt is high before any compare write");
				irq_error = 1'b1;
				o_failed++;
			end
			if (!i_bus.request)
				cycles = 0;
			else if (!i_rsp.ready)
				cycles++;
			else
				check_access();
		end
	end

endmodule

// File: verilog/soc_top.sv
`timescale 1ns/1ps

module soc_top #(
	parameter int RAM_WORDS = 512,
	parameter int SDRAM_WORDS = 4096,
	parameter int SDRAM_LATENCY = 16
)(
	input logic i_clock,
	input logic i_reset,

	input soc_pkg::bus_req_t i_bus,
	output soc_pkg::bus_rsp_t o_bus,

	output logic o_fault,
	output logic [soc_pkg::ADDR_W-1:0] o_fault_address,
	output logic o_timer_interrupt
);

	soc_pkg::bus_req_t ram_req;
	soc_pkg::bus_req_t sdram_req;
	soc_pkg::bus_req_t timer_req;

	soc_pkg::bus_rsp_t ram_rsp;
	soc_pkg::bus_rsp_t sdram_rsp;
	soc_pkg::bus_rsp_t timer_rsp;

	soc_pkg::region_sel_t select;

	// ========================================
	// Fabric
	// ========================================

	soc_bus_decode decode(
		.i_bus(i_bus),
		.o_ram_req(ram_req),
		.o_sdram_req(sdram_req),
		.o_timer_req(timer_req),
		.o_select(select)
	);

	soc_bus_response response(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_bus(i_bus),
		.i_select(select),
		.i_ram_rsp(ram_rsp),
		.i_sdram_rsp(sdram_rsp),
		.i_timer_rsp(timer_rsp),
		.o_bus(o_bus),
		.o_fault(o_fault),
		.o_fault_address(o_fault_address)
	);

	// ========================================
	// Slaves
	// ========================================

	// Fast on-chip RAM
	soc_ram #(
		.WORDS(RAM_WORDS),
		.LATENCY(1)
	) ram(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(ram_req),
		.o_rsp(ram_rsp)
	);

	// Slow memory in place of the SDRAM
	soc_ram #(
		.WORDS(SDRAM_WORDS),
		.LATENCY(SDRAM_LATENCY)
	) sdram(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(sdram_req),
		.o_rsp(sdram_rsp)
	);

	soc_timer timer(
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_req(timer_req),
		.o_rsp(timer_rsp),
		.o_interrupt(o_timer_interrupt)
	);

endmodule

// File: verilog/soc_timer.sv
`timescale 1ns/1ps

module soc_timer(
	input logic i_clock,
	input logic i_reset,

	input soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp,

	output logic o_interrupt
);

	logic [31:0] count;
	logic [31:0] compare;
	logic [2:0] reg_index;
	logic start;
	logic held;
	logic ready;
	logic interrupt;
	logic [soc_pkg::DATA_W-1:0] rdata;

	// Word index already holds address bits 4:2
	assign reg_index = i_req.address[2:0];

	assign start = i_req.request && !held;

	// ========================================
	// Counter and compare
	// ========================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			count <= '0;
			compare <= '1;
			interrupt <= 1'b0;
		end else begin
			count <= count + 1'b1;
			interrupt <= (count >= compare);

			// Count is read only
			if (start && i_req.rw && reg_index == soc_pkg::TIMER_REG_COMPARE)
				compare <= i_req.wdata;
		end
	end

	// ========================================
	// Bus side
	// ========================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			held <= 1'b0;
			ready <= 1'b0;
		end else begin
			ready <= start;
			if (start)
				held <= 1'b1;
			else if (!i_req.request)
				held <= 1'b0;
		end
	end

	// Register read, unknown offsets return zero
	always_ff @(posedge i_clock) begin
		if (start) begin
			case (reg_index)
				soc_pkg::TIMER_REG_COUNT: rdata <= count;
				soc_pkg::TIMER_REG_COMPARE: rdata <= compare;
				default: rdata <= '0;
			endcase
		end
	end

	assign o_rsp.rdata = rdata;
	assign o_rsp.ready = ready;
	assign o_interrupt = interrupt;

endmodule

// File: verilog/soc_ram.sv
`timescale 1ns/1ps

module soc_ram #(
	parameter int WORDS = 512,
	parameter int LATENCY = 1
)(
	input logic i_clock,
	input logic i_reset,

	input soc_pkg::bus_req_t i_req,
	output soc_pkg::bus_rsp_t o_rsp
);

	localparam int IDX_W = (WORDS > 1) ? $clog2(WORDS) : 1;
	localparam int CNT_W = $clog2(LATENCY + 1);

	logic [soc_pkg::DATA_W-1:0] mem [WORDS];

	logic [IDX_W-1:0] index;
	logic start;
	logic held;
	logic [CNT_W-1:0] count;
	logic ready;
	logic [soc_pkg::DATA_W-1:0] rdata;

	// Word index wraps at the region size
	assign index = IDX_W'(i_req.address % soc_pkg::ADDR_W'(WORDS));

	// New access only after request was seen low
	assign start = i_req.request && !held;

	// ========================================
	// Storage
	// ========================================

	always_ff @(posedge i_clock) begin
		if (start) begin
			if (i_req.rw)
				mem[index] <= i_req.wdata;
			rdata <= mem[index];
		end
	end

	// ========================================
	// Response timing
	// ========================================

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			held <= 1'b0;
			count <= '0;
			ready <= 1'b0;
		end else begin
			ready <= 1'b0;

			if (start)
				held <= 1'b1;
			else if (!i_req.request)
				held <= 1'b0;

			if (start) begin
				// Single cycle latency answers straight away
				count <= CNT_W'(LATENCY - 1);
				ready <= (LATENCY == 1);
			end else if (count != '0) begin
				count <= count - 1'b1;
				ready <= (count == CNT_W'(1));
			end
		end
	end

	// rdata stays put until the next access
	assign o_rsp.rdata = rdata;
	assign o_rsp.ready = ready;

endmodule

// File: verilog/soc_bus_response.sv
`timescale 1ns/1ps

module soc_bus_response(
	input logic i_clock,
	input logic i_reset,

	input soc_pkg::bus_req_t i_bus,
	input soc_pkg::region_sel_t i_select,

	input soc_pkg::bus_rsp_t i_ram_rsp,
	input soc_pkg::bus_rsp_t i_sdram_rsp,
	input soc_pkg::bus_rsp_t i_timer_rsp,

	output soc_pkg::bus_rsp_t o_bus,
	output logic o_fault,
	output logic [soc_pkg::ADDR_W-1:0] o_fault_address
);

	logic unmapped;
	logic unmapped_busy;
	logic unmapped_ready;
	logic fault;
	logic [soc_pkg::ADDR_W-1:0] fault_address;

	// ========================================
	// Read data and ready
	// ========================================

	always_comb begin
		if (i_select.ram)
			o_bus.rdata = i_ram_rsp.rdata;
		else if (i_select.sdram)
			o_bus.rdata = i_sdram_rsp.rdata;
		else if (i_select.timer)
			o_bus.rdata = i_timer_rsp.rdata;
		else
			o_bus.rdata = '0;
	end

	assign o_bus.ready =
		i_ram_rsp.ready |
		i_sdram_rsp.ready |
		i_timer_rsp.ready |
		unmapped_ready;

	// ========================================
	// Unmapped access
	// ========================================

	// Request with no region hit
	assign unmapped = i_bus.request && (i_select == '0);

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			unmapped_busy <= 1'b0;
			unmapped_ready <= 1'b0;
			fault <= 1'b0;
			fault_address <= '0;
		end else begin
			unmapped_ready <= 1'b0;
			if (!i_bus.request) begin
				unmapped_busy <= 1'b0;
			end else if (unmapped && !unmapped_busy) begin
				// Complete once so the master can move on
				unmapped_busy <= 1'b1;
				unmapped_ready <= 1'b1;
				// First fault only, later ones keep the record
				if (!fault) begin
					fault <= 1'b1;
					fault_address <= i_bus.address;
				end
			end
		end
	end

	assign o_fault = fault;
	assign o_fault_address = fault_address;

endmodule

// File: verilog/soc_bus_decode.sv
`timescale 1ns/1ps

module soc_bus_decode(
	input soc_pkg::bus_req_t i_bus,

	output soc_pkg::bus_req_t o_ram_req,
	output soc_pkg::bus_req_t o_sdram_req,
	output soc_pkg::bus_req_t o_timer_req,

	output soc_pkg::region_sel_t o_select
);

	// Region code sits in the top four address bits
	localparam int REGION_LSB = soc_pkg::ADDR_W - 4;

	logic [3:0] region;
	logic [soc_pkg::ADDR_W-1:0] offset;
	logic [soc_pkg::ADDR_W-1:0] word_index;

	// Copy of the master request with request masked by the hit
	function automatic soc_pkg::bus_req_t gate_req(
		input soc_pkg::bus_req_t req,
		input logic hit,
		input logic [soc_pkg::ADDR_W-1:0] index
	);
		soc_pkg::bus_req_t gated;
		gated = req;
		gated.request = req.request & hit;
		gated.address = index;
		return gated;
	endfunction

	assign region = i_bus.address[soc_pkg::ADDR_W-1:REGION_LSB];

	// ========================================
	// Region match
	// ========================================

	assign o_select.ram = (region == soc_pkg::REGION_RAM);
	assign o_select.sdram = (region == soc_pkg::REGION_SDRAM);
	assign o_select.timer = (region == soc_pkg::REGION_TIMER);

	// ========================================
	// Local addressing
	// ========================================

	// Offset inside the region, then word index
	assign offset = { 4'h0, i_bus.address[REGION_LSB-1:0] };
	assign word_index = offset >> soc_pkg::WORD_LSH;

	assign o_ram_req = gate_req(i_bus, o_select.ram, word_index);
	assign o_sdram_req = gate_req(i_bus, o_select.sdram, word_index);
	assign o_timer_req = gate_req(i_bus, o_select.timer, word_index);

endmodule

// File: verilog/soc_pkg.sv
package soc_pkg;

	// ========================================
	// Bus widths
	// ========================================

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;

	// Byte address to word index
	localparam int WORD_LSH = 2;

	// ========================================
	// Address map, top nibble of the address
	// ========================================

	localparam logic [3:0] REGION_RAM = 4'h1;
	localparam logic [3:0] REGION_SDRAM = 4'h2;
	localparam logic [3:0] REGION_TIMER = 4'ha;

	// Timer register word offsets, address bits 4:2
	localparam logic [2:0] TIMER_REG_COUNT = 3'd0;
	localparam logic [2:0] TIMER_REG_COMPARE = 3'd1;

	// ========================================
	// Bus payloads
	// ========================================

	// Master side of one access; rw high means write
	typedef struct packed {
		logic request;
		logic rw;
		logic [ADDR_W-1:0] address;
		logic [DATA_W-1:0] wdata;
	} bus_req_t;

	// Slave answer, ready is a single cycle pulse
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
		logic ready;
	} bus_rsp_t;

	// One hot region hit
	typedef struct packed {
		logic ram;
		logic sdram;
		logic timer;
	} region_sel_t;

endpackage
